// ==== design/albuf_pkg.sv ====
/*
  Shared widths, depth constants and vector types of the instruction
  alignment buffer. Every design file imports this package.
*/

package albuf_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  // Response ring entries
  localparam int unsigned ALBUF_DEPTH = 3;
  // Ring index width
  localparam int unsigned ALBUF_PTR_W = 2;
  // Instruction counter width, holds 0 to 6
  localparam int unsigned ALBUF_CNT_W = 3;
  // Requests allowed in flight
  localparam int unsigned MAX_OUTSTANDING = 2;

  ////////////////////
  // Vector types
  ////////////////////

  typedef logic [31:0]            addr_t;
  typedef logic [31:0]            word_t;
  typedef logic [ALBUF_PTR_W-1:0] ptr_t;
  typedef logic [1:0]             ocnt_t;
  typedef logic [ALBUF_CNT_W-1:0] icnt_t;

  // Where the next response word starts, seen from the write side
  //  POS_ALIGNED             word starts a new instruction
  //  POS_UNALIGNED_COMPLETE  unaligned branch, lower half is discarded
  //  POS_UNALIGNED_PARTIAL   lower half ends an instruction begun earlier
  typedef enum logic [1:0] {
    POS_ALIGNED            = 2'b00,
    POS_UNALIGNED_COMPLETE = 2'b01,
    POS_UNALIGNED_PARTIAL  = 2'b10
  } wpos_e;

endpackage

// ==== design/albuf_rd_if.sv ====
/*
  Read side of the response ring. The ring presents its head entry, the
  entry after it and the incoming response; the aligner returns its
  pop and advance strobes.
*/
`timescale 1ns/100ps

interface albuf_rd_if import albuf_pkg::*; ();

  // Entry at the read pointer
  word_t head_data;
  logic  head_err;
  logic  head_valid;
  // Entry at the read pointer plus one
  word_t next_data;
  logic  next_err;
  logic  next_valid;
  // Response passing straight through this cycle
  word_t byp_data;
  logic  byp_err;
  logic  byp_valid;
  // Instruction taken, and head word used up by it
  logic  pop;
  logic  advance;

  modport ring (
    output head_data, head_err, head_valid,
    output next_data, next_err, next_valid,
    output byp_data, byp_err, byp_valid,
    input  pop, advance
  );

  modport aligner (
    input  head_data, head_err, head_valid,
    input  next_data, next_err, next_valid,
    input  byp_data, byp_err, byp_valid,
    output pop, advance
  );

endinterface

// ==== design/fetch_ctrl.sv ====
/*
  Fetch request control. Throttles requests to the prefetcher from the
  number of complete instructions held, tracks requests in flight and
  discards responses that belong to fetches issued before a branch.
*/
`timescale 1ns/100ps

module fetch_ctrl import albuf_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  instr_req_i,
  input  logic  pc_set_i,
  input  logic  kill_i,
  input  addr_t branch_addr_i,
  input  logic  fetch_ready_i,
  input  logic  resp_valid_i,
  input  word_t resp_rdata_i,
  input  logic  pop_i,
  output logic  fetch_valid_o,
  output logic  prefetch_busy_o,
  output ocnt_t outstnd_cnt_o,
  output logic  resp_accept_o
);

  ocnt_t      ocnt_q, ocnt_d;
  ocnt_t      flush_q, flush_d;
  icnt_t      icnt_q, icnt_d;
  icnt_t      icnt_lag;
  wpos_e      wpos_q, wpos_d;
  logic [1:0] n_incoming;
  logic       pop_q;
  logic       lo_full, hi_full;

  ////////////////////
  // Request side
  ////////////////////

  // Pops land in the count one cycle late
  assign icnt_lag = icnt_q - icnt_t'(pop_q);

  // Fetch when nearly empty or on a branch, never past the in-flight limit
  assign fetch_valid_o = instr_req_i && (ocnt_q < ocnt_t'(MAX_OUTSTANDING)) &&
                         ((icnt_lag == '0) ||
                          ((icnt_lag == icnt_t'(1)) && (ocnt_q == '0)) ||
                          pc_set_i);

  assign prefetch_busy_o = (ocnt_q != '0) || fetch_valid_o;
  assign outstnd_cnt_o   = ocnt_q;

  // Stale words are dropped while flushing and in the branch cycle
  assign resp_accept_o = resp_valid_i && (flush_q == '0) && !pc_set_i;

  // Up on an accepted request, down on any response
  always_comb begin
    ocnt_d = ocnt_q;
    unique case ({fetch_valid_o && fetch_ready_i, resp_valid_i})
      2'b10:   ocnt_d = ocnt_q + ocnt_t'(1);
      2'b01:   ocnt_d = ocnt_q - ocnt_t'(1);
      default: ocnt_d = ocnt_q;
    endcase
  end

  // Everything still in flight at a branch gets flushed
  // a response in the branch cycle is already gone
  always_comb begin
    flush_d = flush_q;
    if (pc_set_i) begin
      flush_d = ocnt_q - ocnt_t'(resp_valid_i);
    end else if (resp_valid_i && (flush_q != '0)) begin
      flush_d = flush_q - ocnt_t'(1);
    end
  end

  ////////////////////
  // Instruction count
  ////////////////////

  // Uncompressed halfword markers in the incoming word
  assign lo_full = resp_rdata_i[1:0] == 2'b11;
  assign hi_full = resp_rdata_i[17:16] == 2'b11;

  // Write position tracking, counts instructions completed per word
  always_comb begin
    wpos_d     = wpos_q;
    n_incoming = 2'd0;
    if (pc_set_i) begin
      wpos_d = branch_addr_i[1] ? POS_UNALIGNED_COMPLETE : POS_ALIGNED;
    end else if (resp_accept_o) begin
      unique case (wpos_q)
        POS_ALIGNED: begin
          if (lo_full) begin
            n_incoming = 2'd1;
          end else begin
            // Compressed low half, upper half decides
            n_incoming = hi_full ? 2'd1 : 2'd2;
            wpos_d     = hi_full ? POS_UNALIGNED_PARTIAL : POS_ALIGNED;
          end
        end
        POS_UNALIGNED_COMPLETE: begin
          // Lower half skipped
          n_incoming = hi_full ? 2'd0 : 2'd1;
          wpos_d     = hi_full ? POS_UNALIGNED_PARTIAL : POS_ALIGNED;
        end
        POS_UNALIGNED_PARTIAL: begin
          // Lower half completes the pending instruction
          n_incoming = hi_full ? 2'd1 : 2'd2;
          wpos_d     = hi_full ? POS_UNALIGNED_PARTIAL : POS_ALIGNED;
        end
        default: wpos_d = POS_ALIGNED;
      endcase
    end
  end

  // Buffer content is thrown away on kill and branch
  assign icnt_d = (kill_i || pc_set_i) ? '0 :
                  icnt_q + icnt_t'(n_incoming) - icnt_t'(pop_q);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ocnt_q  <= '0;
      flush_q <= '0;
      icnt_q  <= '0;
      wpos_q  <= POS_ALIGNED;
      pop_q   <= 1'b0;
    end else begin
      ocnt_q  <= ocnt_d;
      flush_q <= flush_d;
      icnt_q  <= icnt_d;
      wpos_q  <= wpos_d;
      pop_q   <= pop_i;
    end
  end

  // In-flight limit holds across request and response interleavings
  a_ocnt_max: assert property (@(posedge clk) disable iff (!rst_n)
    ocnt_q <= ocnt_t'(MAX_OUTSTANDING));

  // Responder only answers requests that were accepted
  a_resp_owed: assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid_i |-> (ocnt_q != '0));

endmodule

// ==== design/resp_ring.sv ====
/*
  Three-entry store for fetched words. Accepted responses are written
  at the write pointer; the aligner reads two entries plus the incoming
  response and retires the head entry through the pop and advance strobes.
*/
`timescale 1ns/100ps

module resp_ring import albuf_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            resp_accept_i,
  input  word_t           resp_rdata_i,
  input  logic            resp_err_i,
  input  logic            pc_set_i,
  input  logic            kill_i,
  albuf_rd_if.ring        rd
);

  word_t                  data_q [ALBUF_DEPTH];
  logic [ALBUF_DEPTH-1:0] err_q;
  logic [ALBUF_DEPTH-1:0] valid_q, valid_d;
  ptr_t                   wptr_q, rptr_q, rptr_nx;
  logic                   retire;

  // Step one entry, wrap after the last
  function automatic ptr_t ptr_inc(ptr_t p);
    return (p == ptr_t'(ALBUF_DEPTH - 1)) ? '0 : p + ptr_t'(1);
  endfunction

  assign rptr_nx = ptr_inc(rptr_q);
  assign retire  = rd.pop && rd.advance;

  ////////////////////
  // Read side
  ////////////////////

  assign rd.head_data  = data_q[rptr_q];
  assign rd.head_err   = err_q[rptr_q];
  assign rd.head_valid = valid_q[rptr_q];
  assign rd.next_data  = data_q[rptr_nx];
  assign rd.next_err   = err_q[rptr_nx];
  assign rd.next_valid = valid_q[rptr_nx];

  // Incoming word, usable in the cycle it arrives
  assign rd.byp_data  = resp_rdata_i;
  assign rd.byp_err   = resp_err_i;
  assign rd.byp_valid = resp_accept_i;

  // Set on write before clear on retire
  // a bypassed word consumed at once ends up invalid
  always_comb begin
    valid_d = valid_q;
    if (resp_accept_i) begin
      valid_d[wptr_q] = 1'b1;
    end
    if (retire) begin
      valid_d[rptr_q] = 1'b0;
    end
    if (kill_i || pc_set_i) begin
      valid_d = '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      wptr_q  <= '0;
      rptr_q  <= '0;
    end else begin
      valid_q <= valid_d;
      if (pc_set_i) begin
        wptr_q <= '0;
        rptr_q <= '0;
      end else begin
        if (resp_accept_i) begin
          wptr_q <= ptr_inc(wptr_q);
        end
        if (retire) begin
          rptr_q <= rptr_nx;
        end
      end
    end
  end

  // Payload storage
  always_ff @(posedge clk) begin
    if (resp_accept_i) begin
      data_q[wptr_q] <= resp_rdata_i;
      err_q[wptr_q]  <= resp_err_i;
    end
  end

  // Request throttling keeps the ring from overflowing
  a_no_overwrite: assert property (@(posedge clk) disable iff (!rst_n)
    (resp_accept_i && !kill_i && !pc_set_i) |-> !valid_q[wptr_q]);

endmodule

// ==== design/instr_aligner.sv ====
/*
  Builds IF stage instructions from the ring read side. Handles aligned
  and halfword-offset instructions, detects compressed encodings, merges
  bus errors of both source words and steps the instruction address.
*/
`timescale 1ns/100ps

module instr_aligner import albuf_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         pc_set_i,
  input  logic         kill_i,
  input  addr_t        branch_addr_i,
  input  logic         instr_ready_i,
  albuf_rd_if.aligner  rd,
  output logic         instr_valid_o,
  output word_t        instr_rdata_o,
  output logic         instr_err_o,
  output addr_t        instr_addr_o
);

  addr_t addr_q;
  logic  killed_q;
  word_t word0, word1, split_word;
  logic  err0, err1, split_err;
  logic  valid0, split_full_valid;
  logic  aligned_c, split_c, cur_c;
  logic  unaligned, avail, handshake;

  ////////////////////
  // Source select
  ////////////////////

  // First word is the head entry, else the incoming response
  assign word0  = rd.head_valid ? rd.head_data : rd.byp_data;
  assign err0   = rd.head_valid ? rd.head_err  : rd.byp_err;
  assign valid0 = rd.head_valid || rd.byp_valid;

  // Second word only matters while the head is valid
  assign word1 = rd.next_valid ? rd.next_data : rd.byp_data;
  assign err1  = rd.next_valid ? rd.next_err  : rd.byp_err;

  // Upper half of first word, lower half of second
  assign split_word = {word1[15:0], word0[31:16]};

  // Need both halves for an uncompressed split instruction
  assign split_full_valid = rd.next_valid || (rd.head_valid && rd.byp_valid);

  // Compressed when the first halfword low bits are not 2'b11
  assign aligned_c = word0[1:0] != 2'b11;
  assign split_c   = word0[17:16] != 2'b11;

  // Errors of every word the instruction touches
  assign split_err = err0 || (!split_c && err1);

  ////////////////////
  // Output
  ////////////////////

  assign unaligned = addr_q[1];
  assign cur_c     = unaligned ? split_c : aligned_c;

  always_comb begin
    if (!unaligned) begin
      avail = valid0;
    end else if (split_c) begin
      avail = valid0;
    end else begin
      avail = split_full_valid;
    end
  end

  // Nothing is handed out while killed or in the branch cycle
  assign instr_valid_o = avail && !kill_i && !pc_set_i && !killed_q;
  assign instr_rdata_o = unaligned ? split_word : word0;
  assign instr_err_o   = unaligned ? split_err  : err0;
  assign instr_addr_o  = addr_q;

  assign handshake = instr_valid_o && instr_ready_i;

  // Head word is used up unless an aligned compressed instr leaves its upper half
  assign rd.pop     = handshake;
  assign rd.advance = unaligned || !aligned_c;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q   <= '0;
      killed_q <= 1'b0;
    end else begin
      if (pc_set_i) begin
        // Halfword aligned branch target
        addr_q <= {branch_addr_i[31:1], 1'b0};
      end else if (handshake) begin
        addr_q <= addr_q + (cur_c ? addr_t'(2) : addr_t'(4));
      end
      // Hold off output from kill until the next branch
      if (pc_set_i) begin
        killed_q <= 1'b0;
      end else if (kill_i) begin
        killed_q <= 1'b1;
      end
    end
  end

  // Address stays on halfword boundaries across branches and steps
  a_addr_half: assert property (@(posedge clk) disable iff (!rst_n)
    instr_addr_o[0] == 1'b0);

endmodule

// ==== design/albuf_top.sv ====
/*
  Top level of the instruction alignment buffer. Ties the fetch control,
  the response ring and the aligner together and presents plain ports
  toward the prefetcher and the IF stage.
*/
`timescale 1ns/100ps

module albuf_top import albuf_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  // Control from the core
  input  logic  instr_req_i,
  input  logic  pc_set_i,
  input  logic  kill_i,
  input  addr_t branch_addr_i,
  // Prefetcher request
  output logic  fetch_valid_o,
  input  logic  fetch_ready_i,
  output logic  fetch_branch_o,
  output addr_t fetch_branch_addr_o,
  // Prefetcher response
  input  logic  resp_valid_i,
  input  word_t resp_rdata_i,
  input  logic  resp_err_i,
  // IF stage
  output logic  instr_valid_o,
  input  logic  instr_ready_i,
  output word_t instr_rdata_o,
  output logic  instr_err_o,
  output addr_t instr_addr_o,
  // Status
  output logic  prefetch_busy_o,
  output ocnt_t outstnd_cnt_o
);

  logic resp_accept;

  albuf_rd_if rd_if ();

  // Branch goes straight to the prefetcher, halfword aligned
  assign fetch_branch_o      = pc_set_i;
  assign fetch_branch_addr_o = {branch_addr_i[31:1], 1'b0};

  fetch_ctrl i_fetch_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .instr_req_i     (instr_req_i),
    .pc_set_i        (pc_set_i),
    .kill_i          (kill_i),
    .branch_addr_i   (branch_addr_i),
    .fetch_ready_i   (fetch_ready_i),
    .resp_valid_i    (resp_valid_i),
    .resp_rdata_i    (resp_rdata_i),
    .pop_i           (rd_if.pop),
    .fetch_valid_o   (fetch_valid_o),
    .prefetch_busy_o (prefetch_busy_o),
    .outstnd_cnt_o   (outstnd_cnt_o),
    .resp_accept_o   (resp_accept)
  );

  resp_ring i_resp_ring (
    .clk           (clk),
    .rst_n         (rst_n),
    .resp_accept_i (resp_accept),
    .resp_rdata_i  (resp_rdata_i),
    .resp_err_i    (resp_err_i),
    .pc_set_i      (pc_set_i),
    .kill_i        (kill_i),
    .rd            (rd_if)
  );

  instr_aligner i_instr_aligner (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_set_i      (pc_set_i),
    .kill_i        (kill_i),
    .branch_addr_i (branch_addr_i),
    .instr_ready_i (instr_ready_i),
    .rd            (rd_if),
    .instr_valid_o (instr_valid_o),
    .instr_rdata_o (instr_rdata_o),
    .instr_err_o   (instr_err_o),
    .instr_addr_o  (instr_addr_o)
  );

endmodule

// ==== test/albuf_tb.sv ====
/*
  Testbench of the instruction alignment buffer. A seeded memory model
  answers fetches in order with random delays. Immediate assertions check
  every taken instruction, the branch request, the counters and the hold
  and kill rules.
*/
`timescale 1ns/100ps

module albuf_tb import albuf_pkg::*; ();

  localparam logic [31:0] IMAGE_SEED = 32'h515b_6308;
  // Words 0x40 to 0x4f answer with a bus error
  localparam addr_t ERR_LO = 32'h0000_0040;
  localparam addr_t ERR_HI = 32'h0000_004f;
  // About 150 instructions at under 10 cycles each plus margin
  localparam int TIMEOUT_CYCLES = 4000;

  logic  clk, rst_n;
  logic  instr_req_i, pc_set_i, kill_i;
  addr_t branch_addr_i;
  logic  fetch_valid_o, fetch_ready_i, fetch_branch_o;
  addr_t fetch_branch_addr_o;
  logic  resp_valid_i, resp_err_i;
  word_t resp_rdata_i;
  logic  instr_valid_o, instr_ready_i, instr_err_o;
  word_t instr_rdata_o;
  addr_t instr_addr_o;
  logic  prefetch_busy_o;
  ocnt_t outstnd_cnt_o;

  integer seed;
  int     cycle_cnt, err_cnt, test_errs, tests_run, tests_failed, hs_count, resp_wait;
  string  cur_test;
  addr_t  req_q[$];
  addr_t  next_fetch, exp_addr, prev_addr;
  word_t  prev_rdata;
  logic   hold_ready, killed, prev_hold;

  albuf_top i_albuf_top (.*);

  always #2 clk = ~clk;

  ////////////////////
  // Memory model
  ////////////////////

  // About 5 in 8 hashed halfwords start an uncompressed instruction
  function automatic logic [15:0] mem_half(addr_t a);
    logic [31:0] h;
    logic [15:0] hw;
    h  = (a * 32'h9e37_79b1) ^ IMAGE_SEED;
    h  = h ^ (h >> 15);
    h  = h * 32'h85eb_ca6b;
    h  = h ^ (h >> 13);
    hw = h[15:0];
    hw[1:0] = (h[18:16] < 3'd5) ? 2'b11 : {1'b0, h[19]};
    return hw;
  endfunction

  function automatic word_t mem_word(addr_t a);
    return {mem_half(a + 32'd2), mem_half(a)};
  endfunction

  function automatic logic in_err_win(addr_t a);
    return (a >= ERR_LO) && (a <= ERR_HI);
  endfunction

  function automatic logic is_compressed(addr_t a);
    logic [15:0] hw;
    hw = mem_half(a);
    return hw[1:0] != 2'b11;
  endfunction

  ////////////////////
  // Prefetcher responder
  ////////////////////

  // Record accepted requests and restart the sequence on a branch
  always @(posedge clk or negedge rst_n) begin
    addr_t base;
    if (!rst_n) begin
      req_q.delete();
      next_fetch = '0;
    end else begin
      base = fetch_branch_o ? (fetch_branch_addr_o & ~32'h3) : next_fetch;
      if (fetch_valid_o && fetch_ready_i) begin
        req_q.push_back(base);
        base = base + 32'd4;
      end
      next_fetch = base;
    end
  end

  // Answer in order after a random gap and toggle both ready inputs at random
  always @(negedge clk) begin
    logic [31:0] r;
    addr_t       a;
    r = $random(seed);
    fetch_ready_i = r[2:0] != 3'd0;
    instr_ready_i = hold_ready ? 1'b0 : (r[9:8] != 2'd0);
    resp_valid_i  = 1'b0;
    if (rst_n && (req_q.size() > 0)) begin
      if (resp_wait == 0) begin
        a = req_q.pop_front();
        resp_valid_i = 1'b1;
        resp_rdata_i = mem_word(a);
        resp_err_i   = in_err_win(a);
        resp_wait    = int'(r[5:4]) % 3;
      end else begin
        resp_wait = resp_wait - 1;
      end
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  task automatic report_value(string what, logic [31:0] exp, logic [31:0] act);
    $display("[FAIL] %s: %s expected %h actual %h", cur_test, what, exp, act);
    err_cnt = err_cnt + 1;
  endtask

  task automatic report_text(string what);
    $display("[FAIL] %s: %s", cur_test, what);
    err_cnt = err_cnt + 1;
  endtask

  // Outputs quiet while reset is held
  always @(posedge clk) begin
    if (!rst_n) begin
      assert (!fetch_valid_o && !instr_valid_o && !prefetch_busy_o && outstnd_cnt_o == '0)
        else report_text("status outputs not low during reset");
    end
  end

  always @(posedge clk) begin
    logic  c;
    logic  exp_err;
    word_t exp_data, mask;
    if (rst_n) begin
      assert (outstnd_cnt_o <= ocnt_t'(2))
        else report_value("outstanding count", 32'd2, 32'(outstnd_cnt_o));
      if (outstnd_cnt_o == '0 && !fetch_valid_o) begin
        assert (!prefetch_busy_o) else report_text("busy set while idle");
      end
      // Branch request toward the prefetcher, target with bit 0 cleared
      assert (fetch_branch_o == pc_set_i)
        else report_value("fetch branch", 32'(pc_set_i), 32'(fetch_branch_o));
      if (pc_set_i) begin
        assert (fetch_branch_addr_o == (branch_addr_i & ~32'h1))
          else report_value("fetch branch address",
                            branch_addr_i & ~32'h1, fetch_branch_addr_o);
      end
      if (kill_i || killed) begin
        assert (!instr_valid_o) else report_text("instruction valid after kill");
      end
      // Held instruction must not change under back-pressure
      if (prev_hold && !kill_i && !pc_set_i) begin
        mask = is_compressed(prev_addr) ? 32'h0000_ffff : 32'hffff_ffff;
        assert (instr_valid_o) else report_text("valid dropped while stalled");
        assert (instr_addr_o == prev_addr)
          else report_value("stalled address", prev_addr, instr_addr_o);
        assert ((instr_rdata_o & mask) == (prev_rdata & mask))
          else report_value("stalled data", prev_rdata & mask, instr_rdata_o & mask);
      end
      if (instr_valid_o && instr_ready_i) begin
        c        = is_compressed(exp_addr);
        exp_data = c ? {16'h0, mem_half(exp_addr)} : mem_word(exp_addr);
        mask     = c ? 32'h0000_ffff : 32'hffff_ffff;
        exp_err  = in_err_win(exp_addr & ~32'h3) ||
                   (!c && in_err_win((exp_addr + 32'd2) & ~32'h3));
        assert (instr_addr_o == exp_addr)
          else report_value("instr address", exp_addr, instr_addr_o);
        assert ((instr_rdata_o & mask) == exp_data)
          else report_value("instr data", exp_data, instr_rdata_o & mask);
        assert (instr_err_o == exp_err)
          else report_value("instr error", 32'(exp_err), 32'(instr_err_o));
        exp_addr = exp_addr + (c ? 32'd2 : 32'd4);
        hs_count = hs_count + 1;
      end
      if (pc_set_i) begin
        exp_addr = branch_addr_i & ~32'h1;
        killed   = 1'b0;
      end else if (kill_i) begin
        killed = 1'b1;
      end
      prev_hold  = instr_valid_o && !instr_ready_i;
      prev_addr  = instr_addr_o;
      prev_rdata = instr_rdata_o;
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles in test %s", cycle_cnt, cur_test);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic start_test(string name);
    cur_test  = name;
    test_errs = err_cnt;
  endtask

  task automatic end_test();
    tests_run = tests_run + 1;
    if (err_cnt == test_errs) begin
      $display("test %s: ok", cur_test);
    end else begin
      tests_failed = tests_failed + 1;
      $display("test %s: %0d errors", cur_test, err_cnt - test_errs);
    end
  endtask

  task automatic branch_to(addr_t target);
    @(negedge clk);
    pc_set_i      = 1'b1;
    branch_addr_i = target;
    @(negedge clk);
    pc_set_i      = 1'b0;
  endtask

  task automatic wait_handshakes(int n);
    int target;
    target = hs_count + n;
    while (hs_count < target) begin
      @(negedge clk);
    end
  endtask

  initial begin
    seed = 32'h515b_6308;
    clk = 1'b0;
    rst_n = 1'b0;
    instr_req_i = 1'b0;
    pc_set_i = 1'b0;
    kill_i = 1'b0;
    branch_addr_i = '0;
    fetch_ready_i = 1'b0;
    resp_valid_i = 1'b0;
    resp_rdata_i = '0;
    resp_err_i = 1'b0;
    instr_ready_i = 1'b0;
    hold_ready = 1'b0;
    killed = 1'b0;
    prev_hold = 1'b0;
    prev_addr = '0;
    prev_rdata = '0;
    exp_addr = '0;
    cycle_cnt = 0;
    err_cnt = 0;
    tests_run = 0;
    tests_failed = 0;
    hs_count = 0;
    resp_wait = 0;
    cur_test = "reset";
    start_test("reset");
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    end_test();

    start_test("sequential");
    instr_req_i = 1'b1;
    branch_to(32'h0000_0000);
    wait_handshakes(40);
    end_test();

    // Branches land while fetches are still in flight
    start_test("branch_aligned");
    branch_to(32'h0000_0200);
    wait_handshakes(30);
    end_test();

    start_test("branch_unaligned");
    branch_to(32'h0000_0303);
    wait_handshakes(30);
    end_test();

    start_test("error_window");
    branch_to(32'h0000_003a);
    wait_handshakes(20);
    end_test();

    start_test("backpressure");
    wait_handshakes(2);
    @(posedge clk);
    hold_ready = 1'b1;
    repeat (12) @(posedge clk);
    hold_ready = 1'b0;
    wait_handshakes(10);
    end_test();

    // Requests stop while killed so late responses fit the ring
    start_test("kill");
    @(negedge clk);
    kill_i      = 1'b1;
    instr_req_i = 1'b0;
    @(negedge clk);
    kill_i = 1'b0;
    repeat (20) @(negedge clk);
    instr_req_i = 1'b1;
    branch_to(32'h0000_0502);
    wait_handshakes(20);
    end_test();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
design/albuf_pkg.sv
design/albuf_rd_if.sv
design/fetch_ctrl.sv
design/resp_ring.sv
design/instr_aligner.sv
design/albuf_top.sv
test/albuf_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the alignment buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module albuf_tb \
  -f flist.f --Mdir obj_dir -o albuf_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/albuf_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "FAIL: see errors above" sim.log; then
  exit 1
fi
exit 0
